//--- source/mipsPkg.sv
package mipsPkg;

    typedef logic [31:0] dataWord_t;
    typedef logic [4:0] regAddr_t;

    // Major opcodes in bits 31:26
    typedef enum logic [5:0] {
        opSpecial = 6'd0,
        opRegimm  = 6'd1,
        opJ       = 6'd2,
        opJal     = 6'd3,
        opBeq     = 6'd4,
        opBne     = 6'd5,
        opBlez    = 6'd6,
        opBgtz    = 6'd7,
        opAddiu   = 6'd9,
        opSlti    = 6'd10,
        opSltiu   = 6'd11,
        opAndi    = 6'd12,
        opOri     = 6'd13,
        opXori    = 6'd14,
        opLui     = 6'd15,
        opLw      = 6'd35,
        opSw      = 6'd43
    } opcode_t;

    // Function codes of SPECIAL
    typedef enum logic [5:0] {
        fnSll  = 6'd0,
        fnSrl  = 6'd2,
        fnSra  = 6'd3,
        fnSllv = 6'd4,
        fnSrlv = 6'd6,
        fnSrav = 6'd7,
        fnJr   = 6'd8,
        fnJalr = 6'd9,
        fnAddu = 6'd33,
        fnSubu = 6'd35,
        fnAnd  = 6'd36,
        fnOr   = 6'd37,
        fnXor  = 6'd38,
        fnSlt  = 6'd42,
        fnSltu = 6'd43
    } funct_t;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu,
        aluSll, aluSrl, aluSra, aluLui
    } aluOp_t;

    typedef enum logic [2:0] {
        clsAluReg, clsAluImm, clsLoad, clsStore,
        clsBranch, clsJump, clsJumpReg, clsIllegal
    } instrClass_t;

    typedef enum logic [2:0] {
        condEq, condNe, condGtz, condLez, condGez, condLtz, condAlways
    } branchCond_t;

    typedef struct packed {
        instrClass_t instrClass;
        aluOp_t      aluOp;
        branchCond_t cond;
        regAddr_t    rs;
        regAddr_t    rt;
        // rd for R-type, rt for I-type, 31 for links
        regAddr_t    dest;
        logic [4:0]  shamt;
        logic        shiftVar;
        dataWord_t   imm;
        logic [25:0] jumpTarget;
        logic        link;
    } decodedInstr_t;

    typedef enum logic [2:0] {
        stFetch, stDecode, stExecute, stMemAccess, stWriteBack, stHalted
    } cpuState_t;

endpackage

//--- source/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder import mipsPkg::*; (
    input  dataWord_t     fetchWord,
    output decodedInstr_t decoded
);

    dataWord_t word;
    opcode_t opcode;
    funct_t funct;
    dataWord_t signImm;
    dataWord_t zeroImm;

    // Bus words carry byte 0 in the low lane
    assign word = {<<8{fetchWord}};
    assign opcode = opcode_t'(word[31:26]);
    assign funct = funct_t'(word[5:0]);
    assign signImm = {{16{word[15]}}, word[15:0]};
    assign zeroImm = {16'b0, word[15:0]};

    always_comb begin
        decoded = '0;
        decoded.instrClass = clsIllegal;
        decoded.aluOp = aluAdd;
        decoded.cond = condAlways;
        decoded.rs = word[25:21];
        decoded.rt = word[20:16];
        decoded.dest = word[20:16];
        decoded.shamt = word[10:6];
        decoded.imm = signImm;
        decoded.jumpTarget = word[25:0];

        case (opcode)
            opSpecial: begin
                decoded.instrClass = clsAluReg;
                decoded.dest = word[15:11];
                case (funct)
                    fnAddu: decoded.aluOp = aluAdd;
                    fnSubu: decoded.aluOp = aluSub;
                    fnAnd:  decoded.aluOp = aluAnd;
                    fnOr:   decoded.aluOp = aluOr;
                    fnXor:  decoded.aluOp = aluXor;
                    fnSlt:  decoded.aluOp = aluSlt;
                    fnSltu: decoded.aluOp = aluSltu;
                    fnSll:  decoded.aluOp = aluSll;
                    fnSrl:  decoded.aluOp = aluSrl;
                    fnSra:  decoded.aluOp = aluSra;
                    fnSllv: begin
                        decoded.aluOp = aluSll;
                        decoded.shiftVar = 1'b1;
                    end
                    fnSrlv: begin
                        decoded.aluOp = aluSrl;
                        decoded.shiftVar = 1'b1;
                    end
                    fnSrav: begin
                        decoded.aluOp = aluSra;
                        decoded.shiftVar = 1'b1;
                    end
                    fnJr:   decoded.instrClass = clsJumpReg;
                    fnJalr: begin
                        decoded.instrClass = clsJumpReg;
                        decoded.link = 1'b1;
                    end
                    default: decoded.instrClass = clsIllegal;
                endcase
            end
            opRegimm: begin
                decoded.instrClass = clsBranch;
                // rt selects the condition, bit 4 requests a link
                case (word[20:16])
                    5'd0:  decoded.cond = condLtz;
                    5'd1:  decoded.cond = condGez;
                    5'd16: decoded.cond = condLtz;
                    5'd17: decoded.cond = condGez;
                    default: decoded.instrClass = clsIllegal;
                endcase
                decoded.link = word[20];
                decoded.dest = 5'd31;
            end
            opJ:     decoded.instrClass = clsJump;
            opJal: begin
                decoded.instrClass = clsJump;
                decoded.link = 1'b1;
                decoded.dest = 5'd31;
            end
            opBeq: begin
                decoded.instrClass = clsBranch;
                decoded.cond = condEq;
            end
            opBne: begin
                decoded.instrClass = clsBranch;
                decoded.cond = condNe;
            end
            opBlez: begin
                decoded.instrClass = clsBranch;
                decoded.cond = condLez;
            end
            opBgtz: begin
                decoded.instrClass = clsBranch;
                decoded.cond = condGtz;
            end
            opAddiu: decoded.instrClass = clsAluImm;
            opSlti: begin
                decoded.instrClass = clsAluImm;
                decoded.aluOp = aluSlt;
            end
            // Sign extended, then compared unsigned
            opSltiu: begin
                decoded.instrClass = clsAluImm;
                decoded.aluOp = aluSltu;
            end
            opAndi: begin
                decoded.instrClass = clsAluImm;
                decoded.aluOp = aluAnd;
                decoded.imm = zeroImm;
            end
            opOri: begin
                decoded.instrClass = clsAluImm;
                decoded.aluOp = aluOr;
                decoded.imm = zeroImm;
            end
            opXori: begin
                decoded.instrClass = clsAluImm;
                decoded.aluOp = aluXor;
                decoded.imm = zeroImm;
            end
            opLui: begin
                decoded.instrClass = clsAluImm;
                decoded.aluOp = aluLui;
            end
            opLw:    decoded.instrClass = clsLoad;
            opSw:    decoded.instrClass = clsStore;
            default: decoded.instrClass = clsIllegal;
        endcase
    end

endmodule

//--- source/registerFile.sv
`timescale 1ns/10ps

module registerFile import mipsPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  regAddr_t  rsAddr,
    input  regAddr_t  rtAddr,
    input  regAddr_t  writeAddr,
    input  logic      writeEnable,
    input  dataWord_t writeData,
    output dataWord_t rsData,
    output dataWord_t rtData,
    output dataWord_t v0
);

    dataWord_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (writeEnable && writeAddr != 5'd0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Register zero is never written, so it reads as zero
    assign rsData = regs[rsAddr];
    assign rtData = regs[rtAddr];
    assign v0 = regs[2];

endmodule

//--- source/aluUnit.sv
`timescale 1ns/10ps

module aluUnit import mipsPkg::*; (
    input  decodedInstr_t instr,
    input  dataWord_t     rsData,
    input  dataWord_t     rtData,
    output dataWord_t     result
);

    dataWord_t opB;
    logic [4:0] shiftAmt;

    // Immediate operand for everything but R-type
    assign opB = (instr.instrClass == clsAluReg) ? rtData : instr.imm;

    // Variable shifts take the low bits of rs
    assign shiftAmt = instr.shiftVar ? rsData[4:0] : instr.shamt;

    // Loads and stores decode as add, giving rs plus offset
    always_comb begin
        case (instr.aluOp)
            aluAdd:  result = rsData + opB;
            aluSub:  result = rsData - opB;
            aluAnd:  result = rsData & opB;
            aluOr:   result = rsData | opB;
            aluXor:  result = rsData ^ opB;
            aluSlt:  result = {31'b0, $signed(rsData) < $signed(opB)};
            aluSltu: result = {31'b0, rsData < opB};
            aluSll:  result = rtData << shiftAmt;
            aluSrl:  result = rtData >> shiftAmt;
            aluSra:  result = $signed(rtData) >>> shiftAmt;
            aluLui:  result = {instr.imm[15:0], 16'b0};
            default: result = rsData + opB;
        endcase
    end

endmodule

//--- source/branchResolver.sv
`timescale 1ns/10ps

module branchResolver import mipsPkg::*; (
    input  decodedInstr_t instr,
    input  dataWord_t     pc,
    input  dataWord_t     rsData,
    input  dataWord_t     rtData,
    output logic          taken,
    output dataWord_t     target,
    output dataWord_t     linkValue
);

    dataWord_t pcPlus4;
    dataWord_t relTarget;
    logic condMet;

    assign pcPlus4 = pc + 32'd4;
    // Offset counts words from the delay slot
    assign relTarget = pcPlus4 + {instr.imm[29:0], 2'b00};
    // Return lands past the delay slot
    assign linkValue = pc + 32'd8;

    always_comb begin
        case (instr.cond)
            condEq:  condMet = (rsData == rtData);
            condNe:  condMet = (rsData != rtData);
            condGtz: condMet = ($signed(rsData) > 0);
            condLez: condMet = ($signed(rsData) <= 0);
            condGez: condMet = ($signed(rsData) >= 0);
            condLtz: condMet = ($signed(rsData) < 0);
            default: condMet = 1'b1;
        endcase
    end

    always_comb begin
        taken = 1'b0;
        target = relTarget;
        case (instr.instrClass)
            clsBranch: taken = condMet;
            clsJump: begin
                taken = 1'b1;
                target = {pcPlus4[31:28], instr.jumpTarget, 2'b00};
            end
            clsJumpReg: begin
                taken = 1'b1;
                target = rsData;
            end
            default: taken = 1'b0;
        endcase
    end

endmodule

//--- source/busController.sv
`timescale 1ns/10ps

module busController import mipsPkg::*; #(
    parameter dataWord_t resetVector = 32'hBFC0_0000
) (
    input  logic          clk,
    input  logic          reset,
    input  decodedInstr_t decoded,
    input  dataWord_t     aluResult,
    input  dataWord_t     branchTarget,
    input  dataWord_t     linkValue,
    input  dataWord_t     rsData,
    input  dataWord_t     rtData,
    input  logic          branchTaken,
    input  logic          waitrequest,
    input  dataWord_t     readdata,
    output dataWord_t     fetchWord,
    output dataWord_t     pc,
    output decodedInstr_t instr,
    output logic          regWriteEnable,
    output regAddr_t      regWriteAddr,
    output dataWord_t     regWriteData,
    output logic          active,
    output logic          read,
    output logic          write,
    output dataWord_t     address,
    output dataWord_t     writedata,
    output logic [3:0]    byteenable
);

    cpuState_t state;
    cpuState_t nextState;
    dataWord_t nextPc;
    dataWord_t followPc;
    logic redirectValid;
    dataWord_t redirectTarget;
    dataWord_t loadData;
    logic isAlu;
    logic isLoad;
    logic isStore;

    assign isAlu = (instr.instrClass == clsAluReg) || (instr.instrClass == clsAluImm);
    assign isLoad = (instr.instrClass == clsLoad);
    assign isStore = (instr.instrClass == clsStore);

    always_comb begin
        nextState = state;
        case (state)
            stFetch: begin
                if (!waitrequest) nextState = stDecode;
            end
            stDecode: begin
                nextState = (decoded.instrClass == clsIllegal) ? stHalted : stExecute;
            end
            stExecute: begin
                // Jump through a zero register ends the program
                if (instr.instrClass == clsJumpReg && rsData == '0) begin
                    nextState = stHalted;
                end else if (isLoad || isStore) begin
                    nextState = stMemAccess;
                end else if (isAlu || instr.link) begin
                    nextState = stWriteBack;
                end else begin
                    nextState = stFetch;
                end
            end
            stMemAccess: begin
                if (!waitrequest) nextState = isLoad ? stWriteBack : stFetch;
            end
            stWriteBack: nextState = stFetch;
            default: nextState = stHalted;
        endcase
    end

    // Address of the instruction after the one in nextPc
    always_comb begin
        followPc = nextPc + 32'd4;
        if (state == stExecute) begin
            if (branchTaken) followPc = branchTarget;
        end else if (redirectValid) begin
            followPc = redirectTarget;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stFetch;
            pc <= resetVector;
            nextPc <= resetVector + 32'd4;
            redirectValid <= 1'b0;
        end else begin
            state <= nextState;
            if (state == stExecute) redirectValid <= branchTaken;
            // Retiring an instruction steps through the delay slot
            if (state != stFetch && nextState == stFetch) begin
                pc <= nextPc;
                nextPc <= followPc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == stFetch && !waitrequest) fetchWord <= readdata;
        if (state == stDecode) instr <= decoded;
        if (state == stExecute) redirectTarget <= branchTarget;
        if (state == stMemAccess && !waitrequest) loadData <= {<<8{readdata}};
    end

    assign active = (state != stHalted);

    // Bus stays idle while reset is held
    assign read = !reset && ((state == stFetch) || (state == stMemAccess && isLoad));
    assign write = !reset && (state == stMemAccess) && isStore;
    assign address = (state == stMemAccess) ? aluResult : pc;
    assign writedata = {<<8{rtData}};
    assign byteenable = 4'b1111;

    assign regWriteEnable = (state == stWriteBack);
    assign regWriteAddr = instr.dest;

    always_comb begin
        if (isLoad) begin
            regWriteData = loadData;
        end else if (instr.link) begin
            regWriteData = linkValue;
        end else begin
            regWriteData = aluResult;
        end
    end

endmodule

//--- source/mipsCpuBus.sv
`timescale 1ns/10ps

module mipsCpuBus import mipsPkg::*; #(
    parameter dataWord_t resetVector = 32'hBFC0_0000
) (
    input  logic       clk,
    input  logic       reset,
    output logic       active,
    output dataWord_t  registerV0,
    output dataWord_t  address,
    output logic       write,
    output logic       read,
    input  logic       waitrequest,
    output dataWord_t  writedata,
    output logic [3:0] byteenable,
    input  dataWord_t  readdata
);

    dataWord_t fetchWord;
    dataWord_t pc;
    decodedInstr_t decoded;
    decodedInstr_t instr;
    dataWord_t rsData;
    dataWord_t rtData;
    dataWord_t aluResult;
    logic branchTaken;
    dataWord_t branchTarget;
    dataWord_t linkValue;
    logic regWriteEnable;
    regAddr_t regWriteAddr;
    dataWord_t regWriteData;

    instrDecoder decoder (
        .fetchWord(fetchWord),
        .decoded(decoded)
    );

    registerFile regs (
        .clk(clk),
        .reset(reset),
        .rsAddr(instr.rs),
        .rtAddr(instr.rt),
        .writeAddr(regWriteAddr),
        .writeEnable(regWriteEnable),
        .writeData(regWriteData),
        .rsData(rsData),
        .rtData(rtData),
        .v0(registerV0)
    );

    aluUnit alu (
        .instr(instr),
        .rsData(rsData),
        .rtData(rtData),
        .result(aluResult)
    );

    branchResolver branch (
        .instr(instr),
        .pc(pc),
        .rsData(rsData),
        .rtData(rtData),
        .taken(branchTaken),
        .target(branchTarget),
        .linkValue(linkValue)
    );

    busController #(
        .resetVector(resetVector)
    ) control (
        .clk(clk),
        .reset(reset),
        .decoded(decoded),
        .aluResult(aluResult),
        .branchTarget(branchTarget),
        .linkValue(linkValue),
        .rsData(rsData),
        .rtData(rtData),
        .branchTaken(branchTaken),
        .waitrequest(waitrequest),
        .readdata(readdata),
        .fetchWord(fetchWord),
        .pc(pc),
        .instr(instr),
        .regWriteEnable(regWriteEnable),
        .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData),
        .active(active),
        .read(read),
        .write(write),
        .address(address),
        .writedata(writedata),
        .byteenable(byteenable)
    );

endmodule

//--- include/tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam logic [31:0] codeBase = 32'hBFC0_0000;
localparam logic [31:0] dataBase = 32'h0000_1000;
localparam int progLength = 60;

logic [31:0] progImage [progLength];

function automatic logic [31:0] codeAddr(input int idx);
    return codeBase + 32'(idx) * 32'd4;
endfunction

function automatic logic [31:0] rType(input int rs, input int rt, input int rd, input int sh,
                                      input funct_t fn);
    return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
endfunction

function automatic logic [31:0] iType(input opcode_t op, input int rs, input int rt,
                                      input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
endfunction

function automatic logic [31:0] jType(input opcode_t op, input int idx);
    logic [31:0] dest;
    dest = codeAddr(idx);
    return {op, dest[27:2]};
endfunction

task automatic buildProgram();
    logic [31:0] jalrDest;
    jalrDest = codeAddr(56);
    for (int i = 0; i < progLength; i++) begin
        progImage[i] = 32'h0;
    end
    // ALU chain, result ends up in v0
    progImage[0] = iType(opLui, 0, 1, 16'h1234);
    progImage[1] = iType(opOri, 1, 1, 16'h5678);
    progImage[2] = iType(opAddiu, 0, 2, 16'hFFFD);
    progImage[3] = rType(1, 2, 3, 0, fnSubu);
    progImage[4] = rType(0, 2, 4, 1, fnSra);
    progImage[5] = rType(4, 1, 5, 0, fnSlt);
    progImage[6] = rType(5, 1, 6, 0, fnSrlv);
    progImage[7] = rType(6, 3, 7, 0, fnXor);
    progImage[8] = iType(opSltiu, 4, 8, 16'hFFFF);
    progImage[9] = iType(opAndi, 1, 9, 16'hF0F0);
    progImage[10] = rType(8, 9, 11, 0, fnSllv);
    progImage[11] = rType(5, 2, 12, 0, fnSrav);
    progImage[12] = rType(0, 1, 13, 4, fnSrl);
    progImage[13] = rType(0, 2, 14, 3, fnSll);
    progImage[14] = iType(opXori, 13, 15, 16'h00FF);
    progImage[15] = iType(opSlti, 2, 16, 16'hFFFE);
    progImage[16] = rType(7, 15, 17, 0, fnAnd);
    progImage[17] = rType(17, 16, 18, 0, fnOr);
    progImage[18] = rType(18, 11, 2, 0, fnAddu);
    progImage[19] = rType(2, 14, 2, 0, fnSubu);
    progImage[20] = rType(2, 12, 2, 0, fnXor);
    progImage[21] = iType(opAddiu, 0, 0, 16'h0005);
    // Stores and a load round trip
    progImage[22] = iType(opAddiu, 0, 10, 16'h1000);
    progImage[23] = iType(opSw, 10, 2, 16'd0);
    progImage[24] = iType(opSw, 10, 0, 16'd4);
    progImage[25] = iType(opLw, 10, 19, 16'd0);
    progImage[26] = iType(opSw, 10, 19, 16'd8);
    // Branches, each followed by its delay slot
    progImage[27] = iType(opBeq, 0, 0, 16'd2);
    progImage[28] = iType(opAddiu, 0, 20, 16'd1);
    progImage[29] = iType(opAddiu, 0, 20, 16'd99);
    progImage[30] = iType(opBne, 0, 0, 16'd5);
    progImage[31] = iType(opAddiu, 0, 21, 16'd2);
    progImage[32] = iType(opBgtz, 5, 0, 16'd1);
    progImage[33] = iType(opAddiu, 0, 22, 16'd3);
    progImage[34] = iType(opRegimm, 4, 16, 16'd2);
    progImage[35] = iType(opSw, 10, 31, 16'd12);
    progImage[36] = iType(opAddiu, 0, 23, 16'd77);
    progImage[37] = iType(opBlez, 5, 0, 16'd3);
    progImage[39] = iType(opRegimm, 5, 1, 16'd1);
    progImage[41] = iType(opRegimm, 5, 0, 16'd3);
    progImage[43] = iType(opRegimm, 0, 17, 16'd2);
    progImage[45] = iType(opAddiu, 0, 23, 16'd77);
    // Jumps
    progImage[46] = jType(opJal, 50);
    progImage[47] = iType(opSw, 10, 31, 16'd16);
    progImage[50] = iType(opLui, 0, 24, codeBase[31:16]);
    progImage[51] = iType(opOri, 24, 24, jalrDest[15:0]);
    progImage[52] = rType(24, 0, 25, 0, fnJalr);
    progImage[53] = iType(opSw, 10, 25, 16'd20);
    progImage[56] = jType(opJ, 59);
    progImage[59] = rType(0, 0, 0, 0, fnJr);
endtask

// Words never fetched because a taken branch jumps over them
function automatic bit isSkipped(input int idx);
    return idx inside {29, 36, 45, 48, 49, 54, 55, 58};
endfunction

function automatic logic [31:0] expectedV0();
    logic [31:0] r1, r2, r3, r4, r5, r6, r7, r8, r9;
    logic [31:0] r11, r12, r13, r14, r15, r16, r17, r18;
    r1 = 32'h1234_5678;
    r2 = 32'hFFFF_FFFD;
    r3 = r1 - r2;
    r4 = $signed(r2) >>> 1;
    r5 = {31'b0, $signed(r4) < $signed(r1)};
    r6 = r1 >> r5[4:0];
    r7 = r6 ^ r3;
    r8 = {31'b0, r4 < 32'hFFFF_FFFF};
    r9 = r1 & 32'h0000_F0F0;
    r11 = r9 << r8[4:0];
    r12 = $signed(r2) >>> r5[4:0];
    r13 = r1 >> 4;
    r14 = r2 << 3;
    r15 = r13 ^ 32'h0000_00FF;
    r16 = {31'b0, $signed(r2) < $signed(32'hFFFF_FFFE)};
    r17 = r7 & r15;
    r18 = r17 | r16;
    return ((r18 + r11) - r14) ^ r12;
endfunction

// Register value stored in each data word, slot n at dataBase + 4n
function automatic logic [31:0] expectedSlot(input int slot);
    case (slot)
        0, 2: return expectedV0();
        3: return codeAddr(36);
        4: return codeAddr(48);
        5: return codeAddr(54);
        default: return 32'h0;
    endcase
endfunction

`endif

//--- tb/tbMipsCpuBus.sv
`timescale 1ns/10ps

module tbMipsCpuBus import mipsPkg::*; ();

    localparam int maxWait = 3;
    localparam int drainCycles = 20;

    logic clk;
    logic reset;
    logic waitrequest;
    dataWord_t readdata;
    logic active;
    dataWord_t registerV0;
    dataWord_t address;
    dataWord_t writedata;
    logic write;
    logic read;
    logic [3:0] byteenable;

    `include "tbProgram.svh"

    localparam int cycleLimit = progLength * 40 * maxWait;

    logic [31:0] mem [logic [31:0]];
    logic [31:0] lfsr;
    int waitRun;
    int cycles;
    int resetCount;
    int traceIdx;
    int haltCycles;
    bit halted;
    bit seenFirst;
    bit pending;
    dataWord_t prevAddress;
    dataWord_t prevWritedata;
    logic prevRead;
    logic prevWrite;

    mipsCpuBus #(
        .resetVector(codeBase)
    ) DUT (
        .clk(clk),
        .reset(reset),
        .active(active),
        .registerV0(registerV0),
        .address(address),
        .write(write),
        .read(read),
        .waitrequest(waitrequest),
        .writedata(writedata),
        .byteenable(byteenable),
        .readdata(readdata)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Byte 0 of a bus word is the register's top byte
    function automatic logic [31:0] swapBytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic logic [31:0] readMem(input logic [31:0] addr);
        return mem.exists(addr) ? mem[addr] : 32'h0;
    endfunction

    task automatic failRun(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        assert (got === expected) else begin
            $display("** Error: %s = %h, expected %h", name, got, expected);
            failRun("value mismatch");
        end
    endtask

    task automatic finishRun();
        checkValue("registerV0", registerV0, expectedV0());
        for (int s = 0; s < 6; s++) begin
            checkValue($sformatf("mem[%h]", dataBase + 32'(s) * 32'd4),
                       readMem(dataBase + 32'(s) * 32'd4), swapBytes(expectedSlot(s)));
        end
        $display("Test passed");
        $finish;
    endtask

    assert property (@(posedge clk) disable iff (reset) byteenable == 4'hF)
        else failRun("byteenable is not all ones");

    assert property (@(posedge clk) disable iff (reset) (read || write) |-> address[1:0] == 2'b00)
        else failRun("bus address is not word aligned");

    initial begin
        reset = 1'b1;
        // Slave busy until the model serves the first fetch
        waitrequest = 1'b1;
        readdata = 32'h0;
        lfsr = 32'h2c209635;
        buildProgram();
        for (int i = 0; i < progLength; i++) begin
            mem[codeAddr(i)] = swapBytes(progImage[i]);
        end
    end

    // Slave model and checks, all on the falling edge
    always @(negedge clk) begin : busModel
        logic nextWait;
        if (reset) begin
            assert (!read && !write) else failRun("read or write high during reset");
            resetCount++;
            if (resetCount >= 5) reset = 1'b0;
        end else begin
            cycles++;
            if (cycles > cycleLimit) failRun("timeout, the core never halted");
            if (!seenFirst) begin
                assert (active && read) else failRun("no fetch in the first cycle after reset");
                checkValue("address", address, codeBase);
                seenFirst = 1'b1;
            end
            if (pending) begin
                checkValue("address", address, prevAddress);
                checkValue("read", {31'b0, read}, {31'b0, prevRead});
                checkValue("write", {31'b0, write}, {31'b0, prevWrite});
                if (write) checkValue("writedata", writedata, prevWritedata);
            end
            if (halted) begin
                assert (!active && !read && !write) else failRun("bus activity after halt");
                haltCycles++;
            end else if (!active) begin
                halted = 1'b1;
                checkValue("fetch count", 32'(traceIdx), 32'(progLength));
            end

            if (read || write) begin
                if (waitRun >= maxWait) begin
                    nextWait = 1'b0;
                end else begin
                    lfsr = lfsrStep(lfsr);
                    nextWait = lfsr[0];
                end
                waitRun = nextWait ? waitRun + 1 : 0;
            end else begin
                nextWait = 1'b0;
                waitRun = 0;
            end
            waitrequest = nextWait;
            readdata = read ? readMem(address) : 32'h0;

            if (!nextWait) begin
                // Code region reads are fetches
                if (read && address[31:28] == codeBase[31:28]) begin
                    while (traceIdx < progLength && isSkipped(traceIdx)) traceIdx++;
                    assert (traceIdx < progLength) else failRun("fetch past end of program");
                    checkValue("fetch address", address, codeAddr(traceIdx));
                    traceIdx++;
                end
                if (write) mem[address] = writedata;
            end
            pending = (read || write) && nextWait;
            prevAddress = address;
            prevWritedata = writedata;
            prevRead = read;
            prevWrite = write;
            if (haltCycles >= drainCycles) finishRun();
        end
    end

endmodule

//--- flist.f
+incdir+include
source/mipsPkg.sv
source/instrDecoder.sv
source/registerFile.sv
source/aluUnit.sv
source/branchResolver.sv
source/busController.sv
source/mipsCpuBus.sv
tb/tbMipsCpuBus.sv

//--- runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbMipsCpuBus -f flist.f -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    exit 1
fi
exit 0
